// ==== all.f ====
+incdir+hw
+incdir+testbench
hw/wb_pkg.sv
hw/wb_fill_pipe.sv
hw/wb_row_buffer.sv
hw/wb_controller.sv
hw/wb_unit.sv
testbench/tb_wb_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the writeback unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --timescale 1ns/10ps -f all.f \
    --top-module tb_wb_unit -o tb_wb_unit; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_wb_unit > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
  echo "pass message not found in $LOG"
  exit 1
fi

echo "simulation passed"
exit 0

// ==== testbench/tb_wb_tasks.svh ====
`ifndef TB_WB_TASKS_SVH
`define TB_WB_TASKS_SVH

// values are widened to a row for printing
task automatic report_mismatch(input string what, input row_t got, input row_t exp);
  $display("ERROR at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
  stop_run();
endtask

task automatic report_timeout(input string what);
  $display("timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
  stop_run();
endtask

task automatic compare_row(input row_t got, input row_t exp, input string what);
  if (got !== exp) begin
    report_mismatch(what, got, exp);
  end
endtask

task automatic compare_paddr(input paddr_t got, input paddr_t exp, input string what);
  if (got !== exp) begin
    report_mismatch(what, row_t'(got), row_t'(exp));
  end
endtask

task automatic compare_data_addr(input data_addr_t got, input data_addr_t exp, input string what);
  if (got !== exp) begin
    report_mismatch(what, row_t'(got), row_t'(exp));
  end
endtask

task automatic compare_opcode(input tl_opcode_t got, input tl_opcode_t exp, input string what);
  if (got !== exp) begin
    report_mismatch(what, row_t'(got), row_t'(exp));
  end
endtask

task automatic compare_bit(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    report_mismatch(what, row_t'(got), row_t'(exp));
  end
endtask

task automatic compare_idx(input idx_t got, input idx_t exp, input string what);
  if (got !== exp) begin
    report_mismatch(what, row_t'(got), row_t'(exp));
  end
endtask

task automatic compare_tag(input tag_t got, input tag_t exp, input string what);
  if (got !== exp) begin
    report_mismatch(what, row_t'(got), row_t'(exp));
  end
endtask

task automatic compare_param(input param_t got, input param_t exp, input string what);
  if (got !== exp) begin
    report_mismatch(what, row_t'(got), row_t'(exp));
  end
endtask

task automatic compare_way(input way_en_t got, input way_en_t exp, input string what);
  if (got !== exp) begin
    report_mismatch(what, row_t'(got), row_t'(exp));
  end
endtask

task automatic compare_count(input int got, input int exp, input string what);
  if (got != exp) begin
    report_mismatch(what, row_t'(got), row_t'(exp));
  end
endtask

// tag and index sit above the block offset
function automatic paddr_t exp_block_addr(input tag_t tag, input idx_t idx);
  return (paddr_t'(tag) << (`WB_IDX_BITS + `WB_BLOCK_OFF_BITS)) |
         (paddr_t'(idx) << `WB_BLOCK_OFF_BITS);
endfunction

// index and row number above the row offset
function automatic data_addr_t exp_data_addr(input idx_t idx, input int unsigned row);
  return (data_addr_t'(idx) << (`WB_ROW_OFF_BITS + ROW_SEL_BITS)) |
         (data_addr_t'(row) << `WB_ROW_OFF_BITS);
endfunction

// one clock, then new ready values for the read and release channels
task automatic next_cycle();
  @(negedge clock);
  if (random_reads) begin
    meta_read_ready = ($urandom % 3) != 0;
    data_req_ready  = ($urandom % 3) != 0;
  end else begin
    meta_read_ready = 1'b1;
    data_req_ready  = 1'b1;
  end
  release_ready = random_release ? (($urandom % 3) == 0) : 1'b1;
endtask

// unit is mid writeback, so the index is busy and no request is taken
task automatic check_busy(input idx_t idx);
  compare_bit(req_ready, 1'b0, "req_ready while busy");
  compare_bit(idx_valid, 1'b1, "idx_valid while busy");
  compare_idx(idx_bits, idx, "idx_bits");
endtask

task automatic clear_records();
  issue_addr_q.delete();
  issue_way_q.delete();
  meta_idx_q.delete();
  meta_tag_q.delete();
  lsu_addr_q.delete();
  beat_data_q.delete();
  beat_opcode_q.delete();
  beat_param_q.delete();
  beat_addr_q.delete();
  fill_done_count = 0;
endtask

task automatic send_request(input idx_t idx, input tag_t tag, input param_t param,
                            input way_en_t way, input logic voluntary);
  next_cycle();
  compare_bit(req_ready, 1'b1, "req_ready before request");
  req_valid     = 1'b1;
  req_idx       = idx;
  req_tag       = tag;
  req_param     = param;
  req_way_en    = way;
  req_voluntary = voluntary;
  next_cycle();
  req_valid = 1'b0;
  // accepted, now filling with both read valids up
  compare_bit(req_ready, 1'b0, "req_ready after accept");
  compare_bit(meta_read_valid, 1'b1, "meta_read_valid after accept");
  compare_bit(data_req_valid, 1'b1, "data_req_valid after accept");
endtask

// beats still owed, so the unit is busy on every pass
task automatic wait_beats(input int count, input idx_t idx);
  int waited;
  waited = 0;
  while (beat_data_q.size() < count) begin
    if (waited == TIMEOUT_CYCLES) begin
      report_timeout("release beats");
    end
    check_busy(idx);
    next_cycle();
    waited++;
  end
endtask

// no grant yet, so the unit must stay busy
task automatic hold_window(input idx_t idx);
  repeat (GRANT_WINDOW) begin
    next_cycle();
    compare_bit(req_ready, 1'b0, "req_ready before grant");
    check_busy(idx);
  end
endtask

task automatic pulse_grant(input idx_t idx);
  mem_grant = 1'b1;
  next_cycle();
  mem_grant = 1'b0;
  check_busy(idx);
endtask

task automatic wait_idle(input idx_t idx);
  int waited;
  waited = 0;
  while (!req_ready) begin
    if (waited == TIMEOUT_CYCLES) begin
      report_timeout("req_ready to return");
    end
    check_busy(idx);
    next_cycle();
    waited++;
  end
  compare_bit(idx_valid, 1'b0, "idx_valid when idle");
endtask

task automatic check_writeback(input idx_t idx, input tag_t tag, input param_t param,
                               input way_en_t way, input logic voluntary);
  tl_opcode_t exp_opcode;
  paddr_t     block_addr;
  exp_opcode = voluntary ? wb_pkg::release_data : probe_ack_data;
  block_addr = exp_block_addr(tag, idx);
  compare_count(issue_addr_q.size(), `WB_REFILL_CYCLES, "read issue count");
  for (int r = 0; r < `WB_REFILL_CYCLES; r++) begin
    compare_data_addr(issue_addr_q[r], exp_data_addr(idx, r), "data_req_addr");
    compare_way(issue_way_q[r], way, "data_req_way_en");
    compare_idx(meta_idx_q[r], idx, "meta_read_idx");
    compare_tag(meta_tag_q[r], tag, "meta_read_tag");
  end
  compare_count(fill_done_count, 1, "fill_done pulses");
  compare_count(lsu_addr_q.size(), 1, "lsu release count");
  compare_paddr(lsu_addr_q[0], block_addr, "lsu_release_address");
  compare_count(beat_data_q.size(), `WB_REFILL_CYCLES, "release beat count");
  // row k goes out on the k-th beat
  for (int r = 0; r < `WB_REFILL_CYCLES; r++) begin
    compare_row(beat_data_q[r], row_pattern(idx, way, r), "release_data");
    compare_opcode(beat_opcode_q[r], exp_opcode, "release_opcode");
    compare_param(beat_param_q[r], param, "release_param");
    compare_paddr(beat_addr_q[r], block_addr, "release_address");
  end
endtask

task automatic run_writeback(input idx_t idx, input tag_t tag, input param_t param,
                             input way_en_t way, input logic voluntary, input int grant_mode);
  clear_records();
  send_request(idx, tag, param, way, voluntary);
  if (grant_mode == GRANT_EARLY) begin
    wait_beats(1, idx);
    pulse_grant(idx);
  end
  wait_beats(`WB_REFILL_CYCLES, idx);
  if (grant_mode == GRANT_LATE) begin
    hold_window(idx);
    pulse_grant(idx);
  end
  wait_idle(idx);
  check_writeback(idx, tag, param, way, voluntary);
endtask

task automatic check_reset_state();
  compare_bit(req_ready, 1'b1, "req_ready after reset");
  compare_bit(meta_read_valid, 1'b0, "meta_read_valid after reset");
  compare_bit(data_req_valid, 1'b0, "data_req_valid after reset");
  compare_bit(lsu_release_valid, 1'b0, "lsu_release_valid after reset");
  compare_bit(release_valid, 1'b0, "release_valid after reset");
  compare_bit(fill_done, 1'b0, "fill_done after reset");
  compare_bit(idx_valid, 1'b0, "idx_valid after reset");
endtask

task automatic probe_all_ready();
  run_writeback(6'h2a, 20'h5_c3a1, 3'd4, 8'b0000_0100, 1'b0, GRANT_NONE);
endtask

// grant after the last beat, then grant while beats are still going out
task automatic voluntary_grants();
  run_writeback(6'h13, 20'ha_0f5e, 3'd1, 8'b1000_0000, 1'b1, GRANT_LATE);
  run_writeback(6'h3f, 20'h0_0001, 3'd2, 8'b0000_0001, 1'b1, GRANT_EARLY);
endtask

task automatic read_backpressure();
  idx_t    idx;
  tag_t    tag;
  param_t  param;
  way_en_t way;
  random_reads = 1'b1;
  repeat (3) begin
    idx   = idx_t'($urandom);
    tag   = tag_t'($urandom);
    param = param_t'($urandom);
    way   = way_en_t'(1 << ($urandom % `WB_WAYS));
    run_writeback(idx, tag, param, way, 1'b0, GRANT_NONE);
  end
  random_reads = 1'b0;
endtask

// stalled beats are checked by the monitor
task automatic release_backpressure();
  random_release = 1'b1;
  run_writeback(6'h05, 20'h3_7b20, 3'd3, 8'b0001_0000, 1'b0, GRANT_NONE);
  random_reads = 1'b1;
  run_writeback(6'h21, 20'hf_e00d, 3'd6, 8'b0000_0010, 1'b1, GRANT_LATE);
  random_reads = 1'b0;
  random_release = 1'b0;
endtask

`endif

// ==== testbench/tb_wb_unit.sv ====
`timescale 1ns/10ps
`include "wb_config.svh"

module tb_wb_unit
  import wb_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 200;
  // cycles req_ready must stay low while a grant is owed
  localparam int GRANT_WINDOW = 20;
  localparam int GRANT_NONE = 0;
  localparam int GRANT_LATE = 1;
  localparam int GRANT_EARLY = 2;
  localparam int ROW_SEL_BITS = $clog2(`WB_REFILL_CYCLES);

  logic       clock = 1'b0;
  logic       reset;
  logic       req_valid;
  logic       req_ready;
  tag_t       req_tag;
  idx_t       req_idx;
  param_t     req_param;
  way_en_t    req_way_en;
  logic       req_voluntary;
  logic       meta_read_valid;
  logic       meta_read_ready;
  idx_t       meta_read_idx;
  tag_t       meta_read_tag;
  logic       data_req_valid;
  logic       data_req_ready;
  way_en_t    data_req_way_en;
  data_addr_t data_req_addr;
  row_t       data_resp = '0;
  logic       fill_done;
  logic       lsu_release_valid;
  logic       lsu_release_ready;
  paddr_t     lsu_release_address;
  logic       release_valid;
  logic       release_ready;
  tl_opcode_t release_opcode;
  param_t     release_param;
  paddr_t     release_address;
  row_t       release_data;
  logic       mem_grant;
  logic       idx_valid;
  idx_t       idx_bits;

  // per run salt mixed into every array row
  logic [31:0] salt;
  // back-pressure modes used by the cycle driver
  bit          random_reads = 1'b0;
  bit          random_release = 1'b0;

  // array model pipeline, two cycles of latency
  logic        read_fire;
  logic        fire_d1 = 1'b0;
  logic        fire_d2 = 1'b0;
  data_addr_t  addr_d1;
  data_addr_t  addr_d2;
  way_en_t     way_d1;
  way_en_t     way_d2;

  // what the DUT did during one writeback
  data_addr_t  issue_addr_q[$];
  way_en_t     issue_way_q[$];
  idx_t        meta_idx_q[$];
  tag_t        meta_tag_q[$];
  paddr_t      lsu_addr_q[$];
  row_t        beat_data_q[$];
  tl_opcode_t  beat_opcode_q[$];
  param_t      beat_param_q[$];
  paddr_t      beat_addr_q[$];
  int          fill_done_count = 0;

  // release beat waiting on release_ready
  logic        beat_pending = 1'b0;
  paddr_t      pending_addr;
  row_t        pending_data;

  wb_unit u_wb_unit (.*);

  always #4 clock = ~clock;

  assign read_fire = meta_read_valid && meta_read_ready && data_req_valid && data_req_ready;

  // array content for set idx, way and row number
  function automatic row_t row_pattern(input idx_t idx, input way_en_t way, input int unsigned row);
    row_t        value;
    logic [31:0] key;
    for (int w = 0; w < `WB_ROW_BITS / 32; w++) begin
      key = {2'b00, idx, way, 8'(row), 8'(w)};
      value[w*32 +: 32] = (key ^ salt) * 32'h9e37_79b1;
    end
    return value;
  endfunction

  // record handshakes and shift the array pipeline
  always @(posedge clock) begin
    fire_d1 <= read_fire;
    fire_d2 <= fire_d1;
    addr_d1 <= data_req_addr;
    addr_d2 <= addr_d1;
    way_d1  <= data_req_way_en;
    way_d2  <= way_d1;
    if (read_fire) begin
      issue_addr_q.push_back(data_req_addr);
      issue_way_q.push_back(data_req_way_en);
      meta_idx_q.push_back(meta_read_idx);
      meta_tag_q.push_back(meta_read_tag);
    end
    if (fill_done) begin
      fill_done_count++;
    end
    if (lsu_release_valid && lsu_release_ready) begin
      lsu_addr_q.push_back(lsu_release_address);
    end
    // a stalled beat keeps its valid, address and data
    if (beat_pending) begin
      compare_bit(release_valid, 1'b1, "release_valid while stalled");
      compare_paddr(release_address, pending_addr, "release_address while stalled");
      compare_row(release_data, pending_data, "release_data while stalled");
    end
    if (release_valid && release_ready) begin
      beat_data_q.push_back(release_data);
      beat_opcode_q.push_back(release_opcode);
      beat_param_q.push_back(release_param);
      beat_addr_q.push_back(release_address);
    end
    beat_pending = release_valid && !release_ready;
    pending_addr = release_address;
    pending_data = release_data;
  end

  // row arrives in the second cycle after its read issued
  always @(negedge clock) begin
    if (fire_d2) begin
      data_resp <= row_pattern(idx_t'(addr_d2 >> (`WB_ROW_OFF_BITS + ROW_SEL_BITS)), way_d2,
                               int'(addr_d2[`WB_ROW_OFF_BITS +: ROW_SEL_BITS]));
    end else begin
      data_resp <= '0;
    end
  end

  task automatic stop_run();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  initial begin
    void'($urandom(32'h92d4));
    salt = $urandom;
    reset = 1'b1;
    req_valid = 1'b0;
    req_tag = '0;
    req_idx = '0;
    req_param = '0;
    req_way_en = '0;
    req_voluntary = 1'b0;
    meta_read_ready = 1'b1;
    data_req_ready = 1'b1;
    lsu_release_ready = 1'b1;
    release_ready = 1'b1;
    mem_grant = 1'b0;
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    check_reset_state();
    probe_all_ready();
    voluntary_grants();
    read_backpressure();
    release_backpressure();
    $display("ALL CHECKS PASSED");
    $finish;
  end

  `include "tb_wb_tasks.svh"

endmodule

// ==== hw/wb_unit.sv ====
`timescale 1ns/10ps

module wb_unit
  import wb_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  // writeback request from the cache
  input  logic       req_valid,
  output logic       req_ready,
  input  tag_t       req_tag,
  input  idx_t       req_idx,
  input  param_t     req_param,
  input  way_en_t    req_way_en,
  input  logic       req_voluntary,
  // metadata array read
  output logic       meta_read_valid,
  input  logic       meta_read_ready,
  output idx_t       meta_read_idx,
  output tag_t       meta_read_tag,
  // data array read and its response
  output logic       data_req_valid,
  input  logic       data_req_ready,
  output way_en_t    data_req_way_en,
  output data_addr_t data_req_addr,
  input  row_t       data_resp,
  output logic       fill_done,
  // load/store unit notice
  output logic       lsu_release_valid,
  input  logic       lsu_release_ready,
  output paddr_t     lsu_release_address,
  // release beats toward outer memory
  output logic       release_valid,
  input  logic       release_ready,
  output tl_opcode_t release_opcode,
  output param_t     release_param,
  output paddr_t     release_address,
  output row_t       release_data,
  input  logic       mem_grant,
  // set index currently being written back
  output logic       idx_valid,
  output idx_t       idx_bits
);

  // read issue toward the fill pipeline
  logic     issue_fire;
  row_cnt_t issue_row;
  // row writes back from the fill pipeline
  logic     row_we;
  row_cnt_t row_wr_sel;
  logic     last_row;
  // row picked for the current release beat
  row_cnt_t beat_sel;

  wb_controller u_controller (
    .clock               (clock),
    .reset               (reset),
    .req_valid           (req_valid),
    .req_ready           (req_ready),
    .req_tag             (req_tag),
    .req_idx             (req_idx),
    .req_param           (req_param),
    .req_way_en          (req_way_en),
    .req_voluntary       (req_voluntary),
    .meta_read_valid     (meta_read_valid),
    .meta_read_ready     (meta_read_ready),
    .meta_read_idx       (meta_read_idx),
    .meta_read_tag       (meta_read_tag),
    .data_req_valid      (data_req_valid),
    .data_req_ready      (data_req_ready),
    .data_req_way_en     (data_req_way_en),
    .data_req_addr       (data_req_addr),
    .issue_fire          (issue_fire),
    .issue_row           (issue_row),
    .last_row            (last_row),
    .fill_done           (fill_done),
    .lsu_release_valid   (lsu_release_valid),
    .lsu_release_ready   (lsu_release_ready),
    .lsu_release_address (lsu_release_address),
    .release_valid       (release_valid),
    .release_ready       (release_ready),
    .release_opcode      (release_opcode),
    .release_param       (release_param),
    .release_address     (release_address),
    .beat_sel            (beat_sel),
    .mem_grant           (mem_grant),
    .idx_valid           (idx_valid),
    .idx_bits            (idx_bits)
  );

  wb_fill_pipe u_fill_pipe (
    .clock      (clock),
    .reset      (reset),
    .issue_fire (issue_fire),
    .issue_row  (issue_row),
    .row_we     (row_we),
    .row_wr_sel (row_wr_sel),
    .last_row   (last_row)
  );

  // buffered row feeds the release data directly
  wb_row_buffer u_row_buffer (
    .clock      (clock),
    .reset      (reset),
    .row_we     (row_we),
    .row_wr_sel (row_wr_sel),
    .data_resp  (data_resp),
    .beat_sel   (beat_sel),
    .beat_row   (release_data)
  );

endmodule

// ==== hw/wb_controller.sv ====
`timescale 1ns/10ps
`include "wb_config.svh"

module wb_controller
  import wb_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  // writeback request
  input  logic       req_valid,
  output logic       req_ready,
  input  tag_t       req_tag,
  input  idx_t       req_idx,
  input  param_t     req_param,
  input  way_en_t    req_way_en,
  input  logic       req_voluntary,
  // metadata read
  output logic       meta_read_valid,
  input  logic       meta_read_ready,
  output idx_t       meta_read_idx,
  output tag_t       meta_read_tag,
  // data array read
  output logic       data_req_valid,
  input  logic       data_req_ready,
  output way_en_t    data_req_way_en,
  output data_addr_t data_req_addr,
  // fill pipeline
  output logic       issue_fire,
  output row_cnt_t   issue_row,
  input  logic       last_row,
  output logic       fill_done,
  // load/store unit notice
  output logic       lsu_release_valid,
  input  logic       lsu_release_ready,
  output paddr_t     lsu_release_address,
  // release toward outer memory
  output logic       release_valid,
  input  logic       release_ready,
  output tl_opcode_t release_opcode,
  output param_t     release_param,
  output paddr_t     release_address,
  output row_cnt_t   beat_sel,
  input  logic       mem_grant,
  // busy index
  output logic       idx_valid,
  output idx_t       idx_bits
);

  localparam int SEL_BITS = $clog2(`WB_REFILL_CYCLES);
  localparam row_cnt_t ROW_COUNT = row_cnt_t'(`WB_REFILL_CYCLES);
  localparam row_cnt_t LAST_BEAT = row_cnt_t'(`WB_REFILL_CYCLES - 1);

  wb_state_t state;
  wb_state_t state_next;
  // counts issued reads while filling, sent beats while active
  row_cnt_t  row_cnt;
  // grant acknowledge seen for this release
  logic      acked;

  // held copy of the accepted request
  tag_t      hold_tag;
  idx_t      hold_idx;
  param_t    hold_param;
  way_en_t   hold_way_en;
  logic      hold_voluntary;

  logic      req_fire;
  logic      lsu_fire;
  logic      release_fire;
  paddr_t    block_addr;

  assign req_fire     = req_valid && req_ready;
  assign lsu_fire     = lsu_release_valid && lsu_release_ready;
  assign release_fire = release_valid && release_ready;
  // a read counts only when meta and data fire together
  assign issue_fire   = meta_read_valid && meta_read_ready && data_req_valid && data_req_ready;

  // tag and index sit above the block offset
  assign block_addr = paddr_t'({hold_tag, hold_idx}) << `WB_BLOCK_OFF_BITS;

  // handshake valids come straight from the state
  assign req_ready         = (state == s_invalid);
  assign meta_read_valid   = (state == s_fill_buffer) && (row_cnt < ROW_COUNT);
  assign data_req_valid    = (state == s_fill_buffer) && (row_cnt < ROW_COUNT);
  assign lsu_release_valid = (state == s_lsu_release);
  assign release_valid     = (state == s_active) && (row_cnt < ROW_COUNT);
  assign fill_done         = (state == s_fill_buffer) && last_row;

  // read payloads
  assign meta_read_idx   = hold_idx;
  assign meta_read_tag   = hold_tag;
  assign data_req_way_en = hold_way_en;
  // index and row number above the row offset
  assign data_req_addr = data_addr_t'({hold_idx, row_cnt[SEL_BITS-1:0]}) << `WB_ROW_OFF_BITS;
  assign issue_row     = row_cnt;

  // release payloads, stable for the whole writeback
  assign lsu_release_address = block_addr;
  assign release_address     = block_addr;
  assign release_param       = hold_param;
  assign release_opcode      = hold_voluntary ? release_data : probe_ack_data;
  assign beat_sel            = row_cnt;

  assign idx_valid = (state != s_invalid);
  assign idx_bits  = hold_idx;

  always_comb begin
    state_next = state;
    case (state)
      s_invalid: begin
        if (req_fire) begin
          state_next = s_fill_buffer;
        end
      end
      s_fill_buffer: begin
        // all rows buffered
        if (last_row) begin
          state_next = s_lsu_release;
        end
      end
      s_lsu_release: begin
        if (lsu_fire) begin
          state_next = s_active;
        end
      end
      s_active: begin
        // voluntary evictions still owe a grant acknowledge
        if (release_fire && (row_cnt == LAST_BEAT)) begin
          state_next = hold_voluntary ? s_grant : s_invalid;
        end
      end
      s_grant: begin
        if (acked) begin
          state_next = s_invalid;
        end
      end
      default: begin
        state_next = s_invalid;
      end
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state   <= s_invalid;
      row_cnt <= '0;
      acked   <= 1'b0;
    end else begin
      state <= state_next;
      case (state)
        s_invalid: begin
          if (req_fire) begin
            row_cnt <= '0;
            acked   <= 1'b0;
          end
        end
        s_fill_buffer: begin
          if (issue_fire) begin
            row_cnt <= row_cnt + 1'b1;
          end
          // rewind so the beats start at row 0
          if (last_row) begin
            row_cnt <= '0;
          end
        end
        s_active: begin
          if (release_fire) begin
            row_cnt <= row_cnt + 1'b1;
          end
          // grant may arrive before the last beat goes out
          if (mem_grant) begin
            acked <= 1'b1;
          end
        end
        s_grant: begin
          if (mem_grant) begin
            acked <= 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // request fields latched on acceptance
  always_ff @(posedge clock) begin
    if (req_fire) begin
      hold_tag       <= req_tag;
      hold_idx       <= req_idx;
      hold_param     <= req_param;
      hold_way_en    <= req_way_en;
      hold_voluntary <= req_voluntary;
    end
  end

endmodule

// ==== hw/wb_row_buffer.sv ====
`timescale 1ns/10ps
`include "wb_config.svh"

module wb_row_buffer
  import wb_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     row_we,
  input  row_cnt_t row_wr_sel,
  input  row_t     data_resp,
  input  row_cnt_t beat_sel,
  output row_t     beat_row
);

  // low bits of a row number address the buffer
  localparam int SEL_BITS = $clog2(`WB_REFILL_CYCLES);

  // one entry per row of the victim block
  row_t rows [`WB_REFILL_CYCLES];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `WB_REFILL_CYCLES; i++) begin
        rows[i] <= '0;
      end
    end else if (row_we) begin
      // capture the array response into its row slot
      rows[row_wr_sel[SEL_BITS-1:0]] <= data_resp;
    end
  end

  // beat counter picks the row sent on the release channel
  // a count past the last row wraps, but no beat is valid then
  assign beat_row = rows[beat_sel[SEL_BITS-1:0]];

endmodule

// ==== hw/wb_fill_pipe.sv ====
`timescale 1ns/10ps
`include "wb_config.svh"

module wb_fill_pipe
  import wb_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     issue_fire,
  input  row_cnt_t issue_row,
  output logic     row_we,
  output row_cnt_t row_wr_sel,
  output logic     last_row
);

  // row number of the final row in a block
  localparam row_cnt_t FINAL_ROW = row_cnt_t'(`WB_REFILL_CYCLES - 1);

  // stage 1 holds the read issued last cycle
  logic     s1_fired;
  row_cnt_t s1_row;
  // stage 2 lines up with the array response
  logic     s2_fired;
  row_cnt_t s2_row;

  // fired flags, one per array latency cycle
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      s1_fired <= 1'b0;
      s2_fired <= 1'b0;
    end else begin
      s1_fired <= issue_fire;
      s2_fired <= s1_fired;
    end
  end

  // row numbers ride along with the flags
  // only looked at when the matching flag is set
  always_ff @(posedge clock) begin
    s1_row <= issue_row;
    s2_row <= s1_row;
  end

  // data_resp holds the row from two cycles back
  assign row_we     = s2_fired;
  assign row_wr_sel = s2_row;

  // final row landing means the block is fully buffered
  assign last_row = s2_fired && (s2_row == FINAL_ROW);

endmodule

// ==== hw/wb_pkg.sv ====
`include "wb_config.svh"

package wb_pkg;

  // one row of block data, as read from the data array
  typedef logic [`WB_ROW_BITS-1:0] row_t;

  // request payload fields
  typedef logic [`WB_TAG_BITS-1:0] tag_t;
  typedef logic [`WB_IDX_BITS-1:0] idx_t;
  typedef logic [`WB_PARAM_BITS-1:0] param_t;
  typedef logic [`WB_WAYS-1:0] way_en_t;

  // block address toward memory and the load/store unit
  typedef logic [`WB_PADDR_BITS-1:0] paddr_t;

  // byte address of a row in the data array: index, row number, row offset
  typedef logic [`WB_IDX_BITS+$clog2(`WB_REFILL_CYCLES)+`WB_ROW_OFF_BITS-1:0] data_addr_t;

  // row number, one bit wider so it can hold the row count itself
  typedef logic [$clog2(`WB_REFILL_CYCLES+1)-1:0] row_cnt_t;

  // release channel opcodes
  typedef enum logic [2:0] {
    probe_ack_data = 3'd5,
    release_data   = 3'd7
  } tl_opcode_t;

  // writeback controller states
  typedef enum logic [2:0] {
    s_invalid,
    s_fill_buffer,
    s_lsu_release,
    s_active,
    s_grant
  } wb_state_t;

endpackage

// ==== hw/wb_config.svh ====
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

// data array row width in bits
`define WB_ROW_BITS 128
// rows that make up one cache block
`define WB_REFILL_CYCLES 4

// request fields
`define WB_TAG_BITS 20
`define WB_IDX_BITS 6
`define WB_PARAM_BITS 3
`define WB_WAYS 8

// address layout
`define WB_PADDR_BITS 32
// byte offset inside a block
`define WB_BLOCK_OFF_BITS 6
// byte offset inside a row
`define WB_ROW_OFF_BITS 4

`endif
